/* fp_decoder.sv */
// Instruction decoder for the kept FP32 non-computational ops
// Anything else comes out as OP_NONE with the illegal flag
`include "fpss_cfg.svh"
`default_nettype none

module fp_decoder (
  input  logic [31:0]                   instr_i,
  output fpss_pkg::fp_op_e              op_o,
  output logic [2:0]                    variant_o,
  output fpss_pkg::op_select_e [1:0]    op_select_o,
  output logic                          illegal_o
);
  import fpss_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode    = instr_i[`FPSS_OPCODE_MSB:`FPSS_OPCODE_LSB];
  assign funct3    = instr_i[`FPSS_F3_MSB:`FPSS_F3_LSB];
  assign funct7    = instr_i[`FPSS_F7_MSB:`FPSS_F7_LSB];
  assign variant_o = funct3;

  always_comb begin
    op_o = OP_NONE;
    if (opcode == `FPSS_OPCODE_OP_FP) begin
      case (funct7)
        `FPSS_F7_SGNJ: begin
          if (funct3 <= 3'd2) op_o = OP_SGNJ;
        end
        `FPSS_F7_MINMAX: begin
          if (funct3 <= 3'd1) op_o = OP_MINMAX;
        end
        `FPSS_F7_CMP: begin
          if (funct3 <= 3'd2) op_o = OP_CMP;
        end
        `FPSS_F7_CLASS_MV: begin
          if (funct3 == 3'd0) begin
            op_o = OP_MV;
          end else if (funct3 == 3'd1) begin
            op_o = OP_CLASS;
          end
        end
        default: op_o = OP_NONE;
      endcase
    end
  end

  // Two-source ops read A and B, class and move only A
  always_comb begin
    case (op_o)
      OP_SGNJ, OP_MINMAX, OP_CMP: begin
        op_select_o[0] = SEL_A;
        op_select_o[1] = SEL_B;
      end
      OP_CLASS, OP_MV: begin
        op_select_o[0] = SEL_A;
        op_select_o[1] = SEL_NONE;
      end
      default: begin
        op_select_o[0] = SEL_NONE;
        op_select_o[1] = SEL_NONE;
      end
    endcase
  end

  assign illegal_o = (op_o == OP_NONE);

endmodule

`default_nettype wire

/* fp_issue.sv */
// Issue stage: decodes the request, selects operands and drives the unit
// Also produces the one-cycle issue strobe per accepted request
`include "fpss_cfg.svh"
`default_nettype none

module fp_issue (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [31:0]           req_op_i,
  input  logic [`FPSS_FLEN-1:0] req_arga_i,
  input  logic [`FPSS_FLEN-1:0] req_argb_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output logic                  issue_o,
  fp_req_if.issue               req
);
  import fpss_pkg::*;

  fp_op_e                dec_op;
  logic [2:0]            dec_variant;
  op_select_e [1:0]      dec_select;
  logic                  dec_illegal;
  logic [`FPSS_FLEN-1:0] operand_a;
  logic [`FPSS_FLEN-1:0] operand_b;
  logic                  issue_q;

  // Empty slots read as all ones
  function automatic logic [`FPSS_FLEN-1:0] pick_operand(
    input op_select_e            sel,
    input logic [`FPSS_FLEN-1:0] arga,
    input logic [`FPSS_FLEN-1:0] argb
  );
    case (sel)
      SEL_A:   return arga;
      SEL_B:   return argb;
      default: return '1;
    endcase
  endfunction

  fp_decoder u_decoder (
    .instr_i     (req_op_i),
    .op_o        (dec_op),
    .variant_o   (dec_variant),
    .op_select_o (dec_select),
    .illegal_o   (dec_illegal)
  );

  assign operand_a = pick_operand(dec_select[0], req_arga_i, req_argb_i);
  assign operand_b = pick_operand(dec_select[1], req_arga_i, req_argb_i);

  // --------------------------------------------------
  // Request to unit
  // --------------------------------------------------
  assign req.valid   = req_valid_i;
  assign req_ready_o = req.ready;

  always_comb begin
    req.payload.op          = dec_op;
    req.payload.variant     = dec_variant;
    req.payload.operands[0] = operand_a;
    req.payload.operands[1] = operand_b;
    req.payload.tag         = fp_tag_t'(req_op_i[`FPSS_RD_MSB:`FPSS_RD_LSB]);
    req.payload.illegal     = dec_illegal;
  end

  // Issue strobe, one cycle after each handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= req_valid_i & req_ready_o;
    end
  end

  assign issue_o = issue_q;

  // Core keeps its request up until it is taken
  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && !req_ready_o |=> req_valid_i);

endmodule

`default_nettype wire

/* fp_noncomp_unit.sv */
// Two-stage FP32 unit for sign injection, move, min/max, compare and classify
// Stage one holds the issued op, stage two the finished result
`include "fpss_cfg.svh"
`default_nettype none

module fp_noncomp_unit (
  input  logic                clk_i,
  input  logic                rst_i,
  fp_req_if.unit              req,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output fpss_pkg::fp_result_t res_o
);
  import fpss_pkg::*;

  localparam logic [`FPSS_FLEN-1:0] canon_nan = 32'h7FC0_0000;

  fp_issue_t             s1_q;
  logic                  s1_valid;
  logic                  s1_ready;
  fp_result_t            res_d;
  logic [`FPSS_FLEN-1:0] op_a;
  logic [`FPSS_FLEN-1:0] op_b;
  logic                  a_nan;
  logic                  b_nan;
  logic                  a_snan;
  logic                  b_snan;
  logic                  both_zero;
  logic                  ord_lt;
  logic                  sgnj_sign;
  logic [`FPSS_FLEN-1:0] minmax_res;
  logic                  cmp_res;
  logic                  cmp_nv;
  logic [9:0]            class_mask;

  function automatic logic is_nan(input logic [`FPSS_FLEN-1:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  // RISC-V class mask, one bit per class
  function automatic logic [9:0] fp_class(input logic [`FPSS_FLEN-1:0] x);
    logic exp_max;
    logic exp_zero;
    logic man_zero;
    exp_max  = &x[30:23];
    exp_zero = ~|x[30:23];
    man_zero = ~|x[22:0];
    if (exp_max) begin
      if (man_zero) return x[31] ? 10'b00_0000_0001 : 10'b00_1000_0000;
      else if (x[22]) return 10'b10_0000_0000;
      else return 10'b01_0000_0000;
    end else if (exp_zero) begin
      if (man_zero) return x[31] ? 10'b00_0000_1000 : 10'b00_0001_0000;
      else return x[31] ? 10'b00_0000_0100 : 10'b00_0010_0000;
    end
    return x[31] ? 10'b00_0000_0010 : 10'b00_0100_0000;
  endfunction

  fp_pipe_reg #(
    .payload_t (fp_issue_t)
  ) u_stage1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req.valid),
    .ready_o (req.ready),
    .data_i  (req.payload),
    .valid_o (s1_valid),
    .ready_i (s1_ready),
    .data_o  (s1_q)
  );

  // --------------------------------------------------
  // Operand properties
  // --------------------------------------------------
  assign op_a      = s1_q.operands[0];
  assign op_b      = s1_q.operands[1];
  assign a_nan     = is_nan(op_a);
  assign b_nan     = is_nan(op_b);
  assign a_snan    = a_nan & ~op_a[22];
  assign b_snan    = b_nan & ~op_b[22];
  assign both_zero = ~|{op_a[30:0], op_b[30:0]};

  // Ordering with -0 below +0, NaNs handled by the callers
  always_comb begin
    if (op_a[31] != op_b[31]) begin
      ord_lt = op_a[31];
    end else if (op_a[31]) begin
      ord_lt = op_b[30:0] < op_a[30:0];
    end else begin
      ord_lt = op_a[30:0] < op_b[30:0];
    end
  end

  always_comb begin
    case (s1_q.variant)
      3'd1:    sgnj_sign = ~op_b[31];
      3'd2:    sgnj_sign = op_a[31] ^ op_b[31];
      default: sgnj_sign = op_b[31];
    endcase
  end

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_res = canon_nan;
    end else if (a_nan) begin
      minmax_res = op_b;
    end else if (b_nan) begin
      minmax_res = op_a;
    end else if (s1_q.variant == 3'd1) begin
      minmax_res = ord_lt ? op_b : op_a;
    end else begin
      minmax_res = ord_lt ? op_a : op_b;
    end
  end

  // Compare: 2 is EQ, 1 is LT, 0 is LE; equal zeros compare equal
  always_comb begin
    cmp_nv = a_nan | b_nan;
    case (s1_q.variant)
      3'd2: begin
        cmp_res = (op_a == op_b) | both_zero;
        cmp_nv  = a_snan | b_snan;
      end
      3'd1:    cmp_res = ord_lt & ~both_zero;
      default: cmp_res = ord_lt | (op_a == op_b) | both_zero;
    endcase
    if (a_nan || b_nan) begin
      cmp_res = 1'b0;
    end
  end

  assign class_mask = fp_class(op_a);

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  always_comb begin
    res_d.data   = '0;
    res_d.status = '0;
    res_d.tag    = s1_q.tag;
    res_d.error  = s1_q.illegal;
    case (s1_q.op)
      OP_SGNJ: res_d.data = {sgnj_sign, op_a[30:0]};
      OP_MV:   res_d.data = op_a;
      OP_MINMAX: begin
        res_d.data      = minmax_res;
        res_d.status.nv = a_snan | b_snan;
      end
      OP_CMP: begin
        res_d.data      = {{(`FPSS_FLEN-1){1'b0}}, cmp_res};
        res_d.status.nv = cmp_nv;
      end
      OP_CLASS: res_d.data = {{(`FPSS_FLEN-10){1'b0}}, class_mask};
      default:  res_d.data = '0;
    endcase
  end

  fp_pipe_reg #(
    .payload_t (fp_result_t)
  ) u_stage2 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (s1_valid),
    .ready_o (s1_ready),
    .data_i  (res_d),
    .valid_o (res_valid_o),
    .ready_i (res_ready_i),
    .data_o  (res_o)
  );

  // Only invalid-operation can be raised by these ops
  a_only_nv: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_o |-> !(res_o.status.dz | res_o.status.of | res_o.status.uf
                      | res_o.status.nx));

endmodule

`default_nettype wire

/* fp_pipe_reg.sv */
// One-entry valid/ready register slice
// Payload type is set per instance
`default_nettype none

module fp_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;

  // Take new data when empty or when the held entry leaves
  assign ready_o = ~full_q | ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

  // Stalled output must hold
  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

/* fp_req_if.sv */
// Issue handshake between the issue stage and the FP unit
// Valid and payload come from the issue side, ready from the unit
`default_nettype none

interface fp_req_if;
  import fpss_pkg::*;

  logic      valid;
  logic      ready;
  fp_issue_t payload;

  modport issue (
    output valid,
    output payload,
    input  ready
  );

  modport unit (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

/* fpss_cfg.svh */
// Shared constants for the FP32 non-computational subsystem
// Include wherever widths or instruction encodings are needed
`ifndef FPSS_CFG_SVH
`define FPSS_CFG_SVH

// Operand and result width
`define FPSS_FLEN 32

// Instruction field positions
`define FPSS_OPCODE_LSB 0
`define FPSS_OPCODE_MSB 6
`define FPSS_RD_LSB 7
`define FPSS_RD_MSB 11
`define FPSS_F3_LSB 12
`define FPSS_F3_MSB 14
`define FPSS_F7_LSB 25
`define FPSS_F7_MSB 31

// OP-FP major opcode and the funct7 groups that are decoded
`define FPSS_OPCODE_OP_FP 7'b1010011
`define FPSS_F7_SGNJ 7'b0010000
`define FPSS_F7_MINMAX 7'b0010100
`define FPSS_F7_CMP 7'b1010000
`define FPSS_F7_CLASS_MV 7'b1110000

// Register stages between request acceptance and response
`define FPSS_PIPE_STAGES 2

`endif

/* fpss_pkg.sv */
// Types shared by the FP subsystem blocks
// Imported by the decoder, issue stage, FP unit and top level
`include "fpss_cfg.svh"
`default_nettype none

package fpss_pkg;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_SGNJ,
    OP_MINMAX,
    OP_CMP,
    OP_CLASS,
    OP_MV
  } fp_op_e;

  // Source of one operand slot
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_A,
    SEL_B
  } op_select_e;

  // Destination register id travels with the op
  typedef logic [4:0] fp_tag_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // Stage one payload
  typedef struct packed {
    fp_op_e                     op;
    logic [2:0]                 variant;
    logic [1:0][`FPSS_FLEN-1:0] operands;
    fp_tag_t                    tag;
    logic                       illegal;
  } fp_issue_t;

  // Stage two payload
  typedef struct packed {
    logic [`FPSS_FLEN-1:0] data;
    fp_status_t            status;
    fp_tag_t               tag;
    logic                  error;
  } fp_result_t;

endpackage

`default_nettype wire

/* fpss_top.sv */
// FP subsystem top with plain accelerator request and response ports
// Requests go through the issue stage into the two-stage FP unit
`include "fpss_cfg.svh"
`default_nettype none

module fpss_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [31:0]           acc_req_op_i,
  input  logic [`FPSS_FLEN-1:0] acc_req_arga_i,
  input  logic [`FPSS_FLEN-1:0] acc_req_argb_i,
  input  logic                  acc_req_valid_i,
  output logic                  acc_req_ready_o,
  output logic [`FPSS_FLEN-1:0] acc_resp_data_o,
  output logic [4:0]            acc_resp_id_o,
  output logic                  acc_resp_error_o,
  output logic                  acc_resp_valid_o,
  input  logic                  acc_resp_ready_i,
  output fpss_pkg::fp_status_t  fpu_status_o,
  output logic                  issue_o
);
  import fpss_pkg::*;

  fp_result_t res;

  fp_req_if u_req_if ();

  fp_issue u_issue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_op_i    (acc_req_op_i),
    .req_arga_i  (acc_req_arga_i),
    .req_argb_i  (acc_req_argb_i),
    .req_valid_i (acc_req_valid_i),
    .req_ready_o (acc_req_ready_o),
    .issue_o     (issue_o),
    .req         (u_req_if.issue)
  );

  fp_noncomp_unit u_unit (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req         (u_req_if.unit),
    .res_valid_o (acc_resp_valid_o),
    .res_ready_i (acc_resp_ready_i),
    .res_o       (res)
  );

  // Response fields
  assign acc_resp_data_o  = res.data;
  assign acc_resp_id_o    = res.tag;
  assign acc_resp_error_o = res.error;
  assign fpu_status_o     = res.status;

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
fpss_pkg.sv
fp_req_if.sv
fp_pipe_reg.sv
fp_decoder.sv
fp_issue.sv
fp_noncomp_unit.sv
fpss_top.sv
tb_fpss.sv

/* tb_fpss.sv */
// Testbench for the FP32 subsystem top level
// Random requests checked by concurrent assertions against a reference model
`include "fpss_cfg.svh"
`default_nettype none

module tb_fpss;
  import fpss_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int DIRECTED_REQS = 36;
  localparam int RANDOM_REQS   = 300;
  localparam int TOTAL_REQS    = DIRECTED_REQS + RANDOM_REQS;

  localparam int K_SGNJ    = 0;
  localparam int K_MINMAX  = 1;
  localparam int K_CMP     = 2;
  localparam int K_CLASS   = 3;
  localparam int K_MV      = 4;
  localparam int K_ILLEGAL = 5;

  typedef struct packed {
    logic [4:0]  id;
    logic [31:0] data;
    logic        error;
    fp_status_t  status;
    logic        timed;
    logic [31:0] cycle;
  } expect_t;

  logic                  clk_i;
  logic                  rst_i;
  logic [31:0]           acc_req_op_i;
  logic [`FPSS_FLEN-1:0] acc_req_arga_i;
  logic [`FPSS_FLEN-1:0] acc_req_argb_i;
  logic                  acc_req_valid_i;
  logic                  acc_req_ready_o;
  logic [`FPSS_FLEN-1:0] acc_resp_data_o;
  logic [4:0]            acc_resp_id_o;
  logic                  acc_resp_error_o;
  logic                  acc_resp_valid_o;
  logic                  acc_resp_ready_i;
  fp_status_t            fpu_status_o;
  logic                  issue_o;

  expect_t     exp_q[$];
  expect_t     exp_head;
  expect_t     cur_exp;
  logic        exp_valid;
  logic [31:0] cycle_cnt;
  logic        latency_phase;
  logic        backpressure;
  int          accepted_count;
  int          delivered_count;
  int          pulse_count;
  int          error_count;

  fpss_top dut0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .acc_req_op_i     (acc_req_op_i),
    .acc_req_arga_i   (acc_req_arga_i),
    .acc_req_argb_i   (acc_req_argb_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_data_o  (acc_resp_data_o),
    .acc_resp_id_o    (acc_resp_id_o),
    .acc_resp_error_o (acc_resp_error_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .fpu_status_o     (fpu_status_o),
    .issue_o          (issue_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_fail(input string msg);
    error_count++;
    $display("[FAIL] t=%0t %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    $display("Problem at time %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic is_nan_value(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan_value(input logic [31:0] x);
    return is_nan_value(x) && !x[22];
  endfunction

  // Monotone key, -0 sorts just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic logic [9:0] class_of(input logic [31:0] x);
    int idx;
    if (x[30:23] == 8'hFF && x[22:0] != 0) idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hFF) idx = x[31] ? 0 : 7;
    else if (x[30:0] == 0) idx = x[31] ? 3 : 4;
    else if (x[30:23] == 0) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 10'd1 << idx;
  endfunction

  // Returns {nv, data}
  function automatic logic [32:0] model_result(input int kind, input logic [2:0] variant,
                                               input logic [31:0] a, input logic [31:0] b);
    logic any_nan;
    logic any_snan;
    logic both_zero;
    logic a_lt;
    logic eq;
    any_nan   = is_nan_value(a) || is_nan_value(b);
    any_snan  = is_snan_value(a) || is_snan_value(b);
    both_zero = (a[30:0] == 0) && (b[30:0] == 0);
    a_lt      = order_key(a) < order_key(b);
    eq        = (a == b) || both_zero;
    case (kind)
      K_SGNJ: begin
        if (variant == 3'd0) return {1'b0, b[31], a[30:0]};
        if (variant == 3'd1) return {1'b0, ~b[31], a[30:0]};
        return {1'b0, a[31] ^ b[31], a[30:0]};
      end
      K_MV: return {1'b0, a};
      K_MINMAX: begin
        if (is_nan_value(a) && is_nan_value(b)) return {any_snan, 32'h7FC0_0000};
        if (is_nan_value(a)) return {any_snan, b};
        if (is_nan_value(b)) return {any_snan, a};
        if (variant == 3'd0) return {any_snan, a_lt ? a : b};
        return {any_snan, a_lt ? b : a};
      end
      K_CMP: begin
        if (variant == 3'd2) return {any_snan, 31'd0, eq && !any_nan};
        if (variant == 3'd1) return {any_nan, 31'd0, a_lt && !both_zero && !any_nan};
        return {any_nan, 31'd0, (a_lt || eq) && !any_nan};
      end
      K_CLASS: return {1'b0, 22'd0, class_of(a)};
      default: return 33'd0;
    endcase
  endfunction

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  function automatic logic [31:0] pool_operand();
    logic [21:0] payload;
    case ($urandom % 10)
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;
      2: return 32'h3F80_0000;
      3: return 32'hBF80_0000;
      4: return 32'h7F80_0000;
      5: return 32'hFF80_0000;
      6: return 32'h7FC0_0000 | ($urandom & 32'h803F_FFFF);
      7: begin
        payload = 22'($urandom);
        if (payload == 0) payload = 22'd1;
        return {1'($urandom), 8'hFF, 1'b0, payload};
      end
      8: return $urandom & 32'h807F_FFFF;
      default: return $urandom;
    endcase
  endfunction

  task automatic make_request(input int kind, output logic [31:0] instr,
                              output logic [31:0] a, output logic [31:0] b,
                              output expect_t e);
    logic [2:0]  variant;
    logic [32:0] model;
    a     = pool_operand();
    b     = pool_operand();
    instr = $urandom;
    instr[`FPSS_OPCODE_MSB:`FPSS_OPCODE_LSB] = `FPSS_OPCODE_OP_FP;
    variant = 3'd0;
    case (kind)
      K_SGNJ: begin
        variant = 3'($urandom % 3);
        instr[`FPSS_F7_MSB:`FPSS_F7_LSB] = `FPSS_F7_SGNJ;
      end
      K_MINMAX: begin
        variant = 3'($urandom % 2);
        instr[`FPSS_F7_MSB:`FPSS_F7_LSB] = `FPSS_F7_MINMAX;
      end
      K_CMP: begin
        variant = 3'($urandom % 3);
        instr[`FPSS_F7_MSB:`FPSS_F7_LSB] = `FPSS_F7_CMP;
      end
      K_CLASS, K_MV: begin
        variant = (kind == K_CLASS) ? 3'd1 : 3'd0;
        instr[`FPSS_F7_MSB:`FPSS_F7_LSB] = `FPSS_F7_CLASS_MV;
        instr[24:20] = 5'd0;
      end
      default: begin
        // Wrong opcode, or a funct3 no kept op uses
        if ($urandom % 2 == 0) begin
          instr[`FPSS_OPCODE_MSB:`FPSS_OPCODE_LSB] = 7'b0110011;
          variant = 3'($urandom);
        end else begin
          instr[`FPSS_F7_MSB:`FPSS_F7_LSB] = `FPSS_F7_SGNJ;
          variant = 3'(3 + $urandom % 5);
        end
      end
    endcase
    instr[`FPSS_F3_MSB:`FPSS_F3_LSB] = variant;
    model    = model_result(kind, variant, a, b);
    e        = '0;
    e.id     = instr[`FPSS_RD_MSB:`FPSS_RD_LSB];
    e.data   = model[31:0];
    e.error  = (kind == K_ILLEGAL);
    e.status.nv = model[32];
    e.timed  = latency_phase;
  endtask

  task automatic send_request(input logic [31:0] instr, input logic [31:0] a,
                              input logic [31:0] b, input expect_t e);
    @(negedge clk_i);
    acc_req_op_i    = instr;
    acc_req_arga_i  = a;
    acc_req_argb_i  = b;
    acc_req_valid_i = 1'b1;
    cur_exp         = e;
    do @(posedge clk_i); while (!acc_req_ready_o);
  endtask

  task automatic stop_requests();
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
  endtask

  task automatic wait_for_drain();
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  always @(negedge clk_i) begin
    acc_resp_ready_i = backpressure ? ($urandom % 3 != 0) : 1'b1;
  end

  // Scoreboard queue, head exposed to the assertions
  always @(posedge clk_i) begin
    expect_t e;
    if (rst_i) begin
      exp_q.delete();
      exp_valid = 1'b0;
      exp_head  = '0;
      cycle_cnt = '0;
    end else begin
      if (acc_resp_valid_o && acc_resp_ready_i && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        delivered_count++;
      end
      if (acc_req_valid_i && acc_req_ready_o) begin
        e       = cur_exp;
        e.cycle = cycle_cnt;
        exp_q.push_back(e);
        accepted_count++;
      end
      if (issue_o) pulse_count++;
      exp_valid = exp_q.size() > 0;
      exp_head  = exp_valid ? exp_q[0] : '0;
      cycle_cnt = cycle_cnt + 1;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_resp_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && acc_resp_ready_i |-> exp_valid)
    else report_problem("response delivered with no request outstanding");

  a_resp_id: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && acc_resp_ready_i && exp_valid |-> acc_resp_id_o == exp_head.id)
    else report_fail($sformatf("id %0d, expected %0d", $sampled(acc_resp_id_o),
                               $sampled(exp_head.id)));

  a_resp_data: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && acc_resp_ready_i && exp_valid |-> acc_resp_data_o == exp_head.data)
    else report_fail($sformatf("data 0x%08h, expected 0x%08h for id %0d",
                               $sampled(acc_resp_data_o), $sampled(exp_head.data),
                               $sampled(exp_head.id)));

  a_resp_error: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && acc_resp_ready_i && exp_valid |-> acc_resp_error_o == exp_head.error)
    else report_fail($sformatf("error bit %0b, expected %0b for id %0d",
                               $sampled(acc_resp_error_o), $sampled(exp_head.error),
                               $sampled(exp_head.id)));

  a_resp_status: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && acc_resp_ready_i && exp_valid |-> fpu_status_o == exp_head.status)
    else report_fail($sformatf("status 0x%02h, expected 0x%02h for id %0d",
                               $sampled(fpu_status_o), $sampled(exp_head.status),
                               $sampled(exp_head.id)));

  a_resp_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && acc_resp_ready_i && exp_valid && exp_head.timed
    |-> cycle_cnt == exp_head.cycle + `FPSS_PIPE_STAGES)
    else report_fail($sformatf("latency %0d cycles, expected %0d",
                               $sampled(cycle_cnt) - $sampled(exp_head.cycle),
                               `FPSS_PIPE_STAGES));

  a_issue_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_o == $past(acc_req_valid_i && acc_req_ready_o))
    else report_fail("issue_o does not match the previous cycle's acceptance");

  a_reset_idle: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !acc_resp_valid_o && !issue_o && acc_req_ready_o)
    else report_problem("outputs not idle after reset");

  initial begin
    #(20 * TOTAL_REQS * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock periods", 20 * TOTAL_REQS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    expect_t     e;
    void'($urandom(32'h2158_598e));
    rst_i            = 1'b1;
    acc_req_op_i     = '0;
    acc_req_arga_i   = '0;
    acc_req_argb_i   = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    cur_exp          = '0;
    latency_phase    = 1'b0;
    backpressure     = 1'b0;
    accepted_count   = 0;
    delivered_count  = 0;
    pulse_count      = 0;
    error_count      = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Every op kind back to back, no back-pressure
    latency_phase = 1'b1;
    for (int i = 0; i < DIRECTED_REQS; i++) begin
      make_request(i % 6, instr, a, b, e);
      send_request(instr, a, b, e);
    end
    stop_requests();
    wait_for_drain();

    // Random mix with idle gaps and a stalling core
    latency_phase = 1'b0;
    backpressure  = 1'b1;
    for (int i = 0; i < RANDOM_REQS; i++) begin
      if ($urandom % 4 == 0) stop_requests();
      make_request(int'($urandom % 6), instr, a, b, e);
      send_request(instr, a, b, e);
    end
    stop_requests();
    backpressure = 1'b0;
    wait_for_drain();
    repeat (4) @(posedge clk_i);

    assert (delivered_count == accepted_count)
      else report_problem("responses were lost");
    assert (pulse_count == accepted_count)
      else report_fail($sformatf("%0d issue pulses for %0d accepted requests",
                                 pulse_count, accepted_count));
    $display("accepted %0d, delivered %0d, issue pulses %0d, errors %0d",
             accepted_count, delivered_count, pulse_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
